// File: pspin_sched_pkg.sv
// Scheduler package with descriptor types, field widths and default sizes
package pspin_sched_pkg;

  // Descriptor field widths
  localparam int unsigned MSG_ID_W   = 8;
  localparam int unsigned PKT_ADDR_W = 16;
  localparam int unsigned PKT_SIZE_W = 8;

  typedef logic [MSG_ID_W-1:0]   msg_id_t;
  typedef logic [PKT_ADDR_W-1:0] pkt_addr_t;
  typedef logic [PKT_SIZE_W-1:0] pkt_size_t;

  // Handler execution request from the NIC
  typedef struct packed {
    msg_id_t   msg_id;
    pkt_addr_t pkt_addr;
    pkt_size_t pkt_size;
  } her_descr_t;

  // Completion returned to the NIC so it can free the buffer
  typedef struct packed {
    msg_id_t   msg_id;
    pkt_addr_t pkt_addr;
  } feedback_descr_t;

  // Default sizes, picked up by the top level
  localparam int unsigned NUM_CLUSTERS_DEF         = 4;
  localparam int unsigned NUM_HERS_PER_CLUSTER_DEF = 2;
  localparam int unsigned HER_FIFO_DEPTH_DEF       = 4;
  localparam int unsigned FB_FIFO_DEPTH_DEF        = 4;

endpackage

// File: desc_fifo.sv
// Descriptor FIFO, a circular buffer shared by HER and feedback queues
`timescale 1ns/10ps

module desc_fifo #(
  parameter type         desc_t = logic,
  parameter int unsigned DEPTH  = 4
) (
  input  logic  clk_i,
  input  logic  rst_i,

  // Write side
  input  logic  in_valid_i,
  output logic  in_ready_o,
  input  desc_t in_data_i,

  // Read side
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output desc_t out_data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  desc_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign in_ready_o  = (count_q != CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // Wrap at DEPTH, which need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: cluster_credit_ctr.sv
// Per-cluster in-flight task counters producing the free-slot vector
`timescale 1ns/10ps

module cluster_credit_ctr #(
  parameter int unsigned NUM_CLUSTERS         = 4,
  parameter int unsigned NUM_HERS_PER_CLUSTER = 2,
  localparam int unsigned IDX_W = (NUM_CLUSTERS > 1) ? $clog2(NUM_CLUSTERS) : 1
) (
  input  logic                    clk_i,
  input  logic                    rst_i,

  // Task handed to a cluster
  input  logic                    issue_i,
  input  logic [IDX_W-1:0]        issue_cluster_i,

  // Feedback taken from a cluster
  input  logic                    release_i,
  input  logic [IDX_W-1:0]        release_cluster_i,

  output logic [NUM_CLUSTERS-1:0] has_credit_o
);

  localparam int unsigned CNT_W = $clog2(NUM_HERS_PER_CLUSTER + 1);

  logic [CNT_W-1:0] count_q [NUM_CLUSTERS];
  logic [NUM_CLUSTERS-1:0] inc;
  logic [NUM_CLUSTERS-1:0] dec;

  always_comb begin
    for (int unsigned i = 0; i < NUM_CLUSTERS; i++) begin
      inc[i] = issue_i && (issue_cluster_i == IDX_W'(i));
      dec[i] = release_i && (release_cluster_i == IDX_W'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int unsigned i = 0; i < NUM_CLUSTERS; i++) begin
        count_q[i] <= '0;
      end
    end else begin
      for (int unsigned i = 0; i < NUM_CLUSTERS; i++) begin
        // Issue and release on the same cluster cancel out
        if (inc[i] && !dec[i]) begin
          count_q[i] <= count_q[i] + 1'b1;
        end else if (dec[i] && !inc[i]) begin
          count_q[i] <= count_q[i] - 1'b1;
        end
      end
    end
  end

  // A cluster can take work while below its slot limit
  always_comb begin
    for (int unsigned i = 0; i < NUM_CLUSTERS; i++) begin
      has_credit_o[i] = (count_q[i] < CNT_W'(NUM_HERS_PER_CLUSTER));
    end
  end

endmodule

// File: task_dispatch_fsm.sv
// Dispatch FSM handing queued HERs to clusters in round-robin order
`timescale 1ns/10ps

module task_dispatch_fsm #(
  parameter int unsigned NUM_CLUSTERS = 4,
  localparam int unsigned IDX_W = (NUM_CLUSTERS > 1) ? $clog2(NUM_CLUSTERS) : 1
) (
  input  logic                        clk_i,
  input  logic                        rst_i,

  // Head of the HER queue
  input  logic                        her_valid_i,
  output logic                        her_ready_o,
  input  pspin_sched_pkg::her_descr_t her_i,

  // Free-slot vector from the counters
  input  logic [NUM_CLUSTERS-1:0]     has_credit_i,

  // Issue pulse to the counters
  output logic                        issue_o,
  output logic [IDX_W-1:0]            issue_cluster_o,

  // Task lanes to the clusters
  output logic [NUM_CLUSTERS-1:0]     task_valid_o,
  input  logic [NUM_CLUSTERS-1:0]     task_ready_i,
  output pspin_sched_pkg::her_descr_t task_o
);

  typedef enum logic {
    IDLE,
    ISSUE
  } state_e;

  state_e                      state_q;
  logic [IDX_W-1:0]            ptr_q;
  logic [IDX_W-1:0]            cluster_q;
  pspin_sched_pkg::her_descr_t task_q;

  logic                        grant_found;
  logic [IDX_W-1:0]            grant_idx;
  logic                        her_take;
  logic                        task_done;

  // First cluster with a free slot, searching from the pointer
  always_comb begin
    int unsigned cand;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int unsigned k = 0; k < NUM_CLUSTERS; k++) begin
      cand = ptr_q + k;
      if (cand >= NUM_CLUSTERS) begin
        cand = cand - NUM_CLUSTERS;
      end
      if (!grant_found && has_credit_i[cand]) begin
        grant_found = 1'b1;
        grant_idx   = IDX_W'(cand);
      end
    end
  end

  assign her_ready_o = (state_q == IDLE) && grant_found;
  assign her_take    = her_valid_i && her_ready_o;
  assign task_done   = (state_q == ISSUE) && task_ready_i[cluster_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      ptr_q     <= '0;
      cluster_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (her_take) begin
            state_q   <= ISSUE;
            cluster_q <= grant_idx;
            // Next search starts after the granted cluster
            ptr_q <= (grant_idx == IDX_W'(NUM_CLUSTERS - 1)) ? '0 : grant_idx + 1'b1;
          end
        end
        ISSUE: begin
          if (task_done) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Task payload held while waiting for the cluster
  always_ff @(posedge clk_i) begin
    if (her_take) begin
      task_q <= her_i;
    end
  end

  always_comb begin
    task_valid_o = '0;
    if (state_q == ISSUE) begin
      task_valid_o[cluster_q] = 1'b1;
    end
  end

  assign task_o          = task_q;
  assign issue_o         = task_done;
  assign issue_cluster_o = cluster_q;

endmodule

// File: feedback_collect.sv
// Round-robin collector of cluster feedback that releases credits
`timescale 1ns/10ps

module feedback_collect #(
  parameter int unsigned NUM_CLUSTERS = 4,
  localparam int unsigned IDX_W = (NUM_CLUSTERS > 1) ? $clog2(NUM_CLUSTERS) : 1
) (
  input  logic                                                clk_i,
  input  logic                                                rst_i,

  // Feedback lanes from the clusters
  input  logic [NUM_CLUSTERS-1:0]                             cluster_fb_valid_i,
  output logic [NUM_CLUSTERS-1:0]                             cluster_fb_ready_o,
  input  pspin_sched_pkg::feedback_descr_t [NUM_CLUSTERS-1:0] cluster_fb_i,

  // Into the feedback queue
  output logic                                                fb_valid_o,
  input  logic                                                fb_ready_i,
  output pspin_sched_pkg::feedback_descr_t                    fb_o,

  // Credit return to the counters
  output logic                                                release_o,
  output logic [IDX_W-1:0]                                    release_cluster_o
);

  logic [IDX_W-1:0] ptr_q;
  logic             grant_found;
  logic [IDX_W-1:0] grant_idx;
  logic             accept;

  // Pick the first valid lane at or after the pointer
  always_comb begin
    int unsigned cand;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int unsigned k = 0; k < NUM_CLUSTERS; k++) begin
      cand = ptr_q + k;
      if (cand >= NUM_CLUSTERS) begin
        cand = cand - NUM_CLUSTERS;
      end
      if (!grant_found && cluster_fb_valid_i[cand]) begin
        grant_found = 1'b1;
        grant_idx   = IDX_W'(cand);
      end
    end
  end

  assign accept     = grant_found && fb_ready_i;
  assign fb_valid_o = grant_found;
  assign fb_o       = cluster_fb_i[grant_idx];

  // Only the granted lane sees ready, and only if the queue has room
  always_comb begin
    cluster_fb_ready_o = '0;
    cluster_fb_ready_o[grant_idx] = accept;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (accept) begin
      ptr_q <= (grant_idx == IDX_W'(NUM_CLUSTERS - 1)) ? '0 : grant_idx + 1'b1;
    end
  end

  assign release_o         = accept;
  assign release_cluster_o = grant_idx;

endmodule

// File: pspin_sched_top.sv
// Inter-cluster scheduler top level with queues, counters, dispatcher and collector
`timescale 1ns/10ps

module pspin_sched_top #(
  parameter int unsigned NUM_CLUSTERS         = pspin_sched_pkg::NUM_CLUSTERS_DEF,
  parameter int unsigned NUM_HERS_PER_CLUSTER = pspin_sched_pkg::NUM_HERS_PER_CLUSTER_DEF,
  parameter int unsigned HER_FIFO_DEPTH       = pspin_sched_pkg::HER_FIFO_DEPTH_DEF,
  parameter int unsigned FB_FIFO_DEPTH        = pspin_sched_pkg::FB_FIFO_DEPTH_DEF
) (
  input  logic                                                clk_i,
  input  logic                                                rst_i,

  // HERs from the NIC
  input  logic                                                her_valid_i,
  output logic                                                her_ready_o,
  input  pspin_sched_pkg::her_descr_t                         her_i,

  // Tasks to the clusters
  output logic [NUM_CLUSTERS-1:0]                             task_valid_o,
  input  logic [NUM_CLUSTERS-1:0]                             task_ready_i,
  output pspin_sched_pkg::her_descr_t                         task_o,

  // Feedback from the clusters
  input  logic [NUM_CLUSTERS-1:0]                             cluster_fb_valid_i,
  output logic [NUM_CLUSTERS-1:0]                             cluster_fb_ready_o,
  input  pspin_sched_pkg::feedback_descr_t [NUM_CLUSTERS-1:0] cluster_fb_i,

  // Feedback to the NIC
  output logic                                                nic_fb_valid_o,
  input  logic                                                nic_fb_ready_i,
  output pspin_sched_pkg::feedback_descr_t                    nic_fb_o
);

  localparam int unsigned IDX_W = (NUM_CLUSTERS > 1) ? $clog2(NUM_CLUSTERS) : 1;

  // HER queue -> dispatcher
  logic                             head_valid;
  logic                             head_ready;
  pspin_sched_pkg::her_descr_t      head_her;

  // Dispatcher and collector -> counters
  logic                             issue;
  logic [IDX_W-1:0]                 issue_cluster;
  logic                             release_fb;
  logic [IDX_W-1:0]                 release_cluster;
  logic [NUM_CLUSTERS-1:0]          has_credit;

  // Collector -> feedback queue
  logic                             fb_valid;
  logic                             fb_ready;
  pspin_sched_pkg::feedback_descr_t fb;

  desc_fifo #(
    .desc_t      (pspin_sched_pkg::her_descr_t),
    .DEPTH       (HER_FIFO_DEPTH)
  ) i_her_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (her_valid_i),
    .in_ready_o  (her_ready_o),
    .in_data_i   (her_i),
    .out_valid_o (head_valid),
    .out_ready_i (head_ready),
    .out_data_o  (head_her)
  );

  cluster_credit_ctr #(
    .NUM_CLUSTERS         (NUM_CLUSTERS),
    .NUM_HERS_PER_CLUSTER (NUM_HERS_PER_CLUSTER)
  ) i_credit (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .issue_i              (issue),
    .issue_cluster_i      (issue_cluster),
    .release_i            (release_fb),
    .release_cluster_i    (release_cluster),
    .has_credit_o         (has_credit)
  );

  task_dispatch_fsm #(
    .NUM_CLUSTERS    (NUM_CLUSTERS)
  ) i_dispatch (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .her_valid_i     (head_valid),
    .her_ready_o     (head_ready),
    .her_i           (head_her),
    .has_credit_i    (has_credit),
    .issue_o         (issue),
    .issue_cluster_o (issue_cluster),
    .task_valid_o    (task_valid_o),
    .task_ready_i    (task_ready_i),
    .task_o          (task_o)
  );

  feedback_collect #(
    .NUM_CLUSTERS       (NUM_CLUSTERS)
  ) i_fb_collect (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .cluster_fb_valid_i (cluster_fb_valid_i),
    .cluster_fb_ready_o (cluster_fb_ready_o),
    .cluster_fb_i       (cluster_fb_i),
    .fb_valid_o         (fb_valid),
    .fb_ready_i         (fb_ready),
    .fb_o               (fb),
    .release_o          (release_fb),
    .release_cluster_o  (release_cluster)
  );

  desc_fifo #(
    .desc_t      (pspin_sched_pkg::feedback_descr_t),
    .DEPTH       (FB_FIFO_DEPTH)
  ) i_fb_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (fb_valid),
    .in_ready_o  (fb_ready),
    .in_data_i   (fb),
    .out_valid_o (nic_fb_valid_o),
    .out_ready_i (nic_fb_ready_i),
    .out_data_o  (nic_fb_o)
  );

endmodule

// File: tb_pspin_sched.sv
// Testbench for the inter-cluster scheduler with cluster models and a feedback scoreboard
`timescale 1ns/10ps

module tb_pspin_sched;

  localparam int unsigned NC       = pspin_sched_pkg::NUM_CLUSTERS_DEF;
  localparam int unsigned NH       = pspin_sched_pkg::NUM_HERS_PER_CLUSTER_DEF;
  localparam int unsigned HD       = pspin_sched_pkg::HER_FIFO_DEPTH_DEF;
  localparam int unsigned FD       = pspin_sched_pkg::FB_FIFO_DEPTH_DEF;
  localparam int unsigned SLOTS    = NC * NH;
  localparam int unsigned NUM_HERS = 60;
  // About 30 cycles per HER covers the stall windows and the throttled phase
  localparam int unsigned TIMEOUT_CYCLES = NUM_HERS * 30 + 200;
  localparam int unsigned FB_W = $bits(pspin_sched_pkg::feedback_descr_t);

  logic                                      clk;
  logic                                      rst;
  logic                                      her_valid;
  logic                                      her_ready;
  pspin_sched_pkg::her_descr_t               her;
  logic [NC-1:0]                             task_valid;
  logic [NC-1:0]                             task_ready;
  pspin_sched_pkg::her_descr_t               task_data;
  logic [NC-1:0]                             cluster_fb_valid;
  logic [NC-1:0]                             cluster_fb_ready;
  pspin_sched_pkg::feedback_descr_t [NC-1:0] cluster_fb;
  logic                                      nic_fb_valid;
  logic                                      nic_fb_ready;
  pspin_sched_pkg::feedback_descr_t          nic_fb;

  // Stimulus control from the main sequence
  int unsigned her_budget = 0;
  logic        fb_hold = 1'b1;
  logic        task_pattern = 1'b0;
  logic [1:0]  nic_mode = 2'd1;

  // Observed traffic and model state
  int unsigned                 cycle = 0;
  int unsigned                 her_sent = 0;
  int unsigned                 her_acc = 0;
  int unsigned                 task_cnt = 0;
  int unsigned                 fb_taken = 0;
  int unsigned                 fb_delivered = 0;
  logic                        her_fire = 1'b0;
  logic [NC-1:0]               fb_take = '0;
  logic [31:0]                 lfsr = 32'hdfb0;
  int                          inflight [NC];
  int unsigned                 fb_wait [NC];
  int unsigned                 grant_log [$];
  pspin_sched_pkg::her_descr_t exp_task_q [$];
  pspin_sched_pkg::her_descr_t rx_q [NC][$];
  int unsigned                 exp_fb [logic [FB_W-1:0]];
  int unsigned                 fb_base;

  pspin_sched_top i_dut (
    .clk_i              (clk),
    .rst_i              (rst),
    .her_valid_i        (her_valid),
    .her_ready_o        (her_ready),
    .her_i              (her),
    .task_valid_o       (task_valid),
    .task_ready_i       (task_ready),
    .task_o             (task_data),
    .cluster_fb_valid_i (cluster_fb_valid),
    .cluster_fb_ready_o (cluster_fb_ready),
    .cluster_fb_i       (cluster_fb),
    .nic_fb_valid_o     (nic_fb_valid),
    .nic_fb_ready_i     (nic_fb_ready),
    .nic_fb_o           (nic_fb)
  );

  // Expected completion for a task
  function automatic pspin_sched_pkg::feedback_descr_t expected_feedback(
    input pspin_sched_pkg::her_descr_t t
  );
    pspin_sched_pkg::feedback_descr_t fb;
    fb.msg_id   = t.msg_id;
    fb.pkt_addr = t.pkt_addr;
    return fb;
  endfunction

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    fail_run($sformatf("Mismatch at %0t: %s is 'h%0h, expected 'h%0h",
                       $time, name, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle > TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout after %0d cycles", cycle));
    end
  end

  // NIC side HER source
  always @(posedge clk) begin
    #1;
    if (her_valid && her_fire) begin
      her_valid = 1'b0;
    end
    if (!her_valid && her_sent < her_budget) begin
      her.msg_id   = pspin_sched_pkg::msg_id_t'(take_bits(8));
      her.pkt_addr = pspin_sched_pkg::pkt_addr_t'(take_bits(16));
      her.pkt_size = pspin_sched_pkg::pkt_size_t'(take_bits(8));
      her_valid    = 1'b1;
      her_sent++;
    end
  end

  // Ready patterns of the clusters and the NIC
  always @(posedge clk) begin
    #1;
    for (int unsigned c = 0; c < NC; c++) begin
      task_ready[c] = task_pattern ? (((cycle + c) % 3) != 0) : 1'b1;
    end
    case (nic_mode)
      2'd0: nic_fb_ready = 1'b0;
      2'd1: nic_fb_ready = 1'b1;
      default: nic_fb_ready = ((cycle % 4) != 1);
    endcase
  end

  // Cluster models return feedback a few cycles after each task
  always @(posedge clk) begin
    #1;
    for (int unsigned c = 0; c < NC; c++) begin
      if (fb_take[c]) begin
        cluster_fb_valid[c] = 1'b0;
        void'(rx_q[c].pop_front());
        fb_wait[c] = c + 1;
      end
      if (!cluster_fb_valid[c] && rx_q[c].size() > 0 && !fb_hold) begin
        if (fb_wait[c] == 0) begin
          cluster_fb[c].msg_id   = rx_q[c][0].msg_id;
          cluster_fb[c].pkt_addr = rx_q[c][0].pkt_addr;
          cluster_fb_valid[c]    = 1'b1;
        end else begin
          fb_wait[c]--;
        end
      end
    end
  end

  // Handshake checks on the falling edge
  always @(negedge clk) begin : compare
    pspin_sched_pkg::her_descr_t exp_t;
    if (!rst) begin
      her_fire = her_valid && her_ready;
      if (her_fire) begin
        exp_task_q.push_back(her);
        her_acc++;
      end
      assert ($countones(task_valid) <= 1) else fail_run("Two task lanes valid at once");
      for (int unsigned c = 0; c < NC; c++) begin
        if (task_valid[c] && task_ready[c]) begin
          assert (exp_task_q.size() > 0)
            else fail_run("Task issued without an accepted HER");
          exp_t = exp_task_q.pop_front();
          assert (task_data == exp_t) else report_mismatch("task_o", task_data, exp_t);
          grant_log.push_back(c);
          rx_q[c].push_back(task_data);
          exp_fb[expected_feedback(exp_t)]++;
          task_cnt++;
          inflight[c]++;
          assert (inflight[c] <= NH)
            else fail_run("A cluster holds more tasks than its slots");
        end
        fb_take[c] = cluster_fb_valid[c] && cluster_fb_ready[c];
        if (fb_take[c]) begin
          inflight[c]--;
          fb_taken++;
        end
      end
      if (nic_fb_valid && nic_fb_ready) begin
        assert (exp_fb.exists(nic_fb)) else fail_run("Feedback at the NIC matches no task");
        exp_fb[nic_fb]--;
        if (exp_fb[nic_fb] == 0) begin
          exp_fb.delete(nic_fb);
        end
        fb_delivered++;
      end
    end
  end

  initial begin
    her_valid        = 1'b0;
    her              = '0;
    task_ready       = '0;
    cluster_fb_valid = '0;
    cluster_fb       = '0;
    nic_fb_ready     = 1'b0;
    foreach (inflight[c]) begin
      inflight[c] = 0;
      fb_wait[c]  = 0;
    end
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    next_cycle();
    assert (her_ready && task_valid == '0 && !nic_fb_valid)
      else fail_run("Outputs not idle after reset");

    // Fill every slot and then the HER queue while feedback is held back
    her_budget = 20;
    while (task_cnt < SLOTS || her_acc < SLOTS + HD) next_cycle();
    for (int unsigned i = 0; i < SLOTS; i++) begin
      assert (grant_log[i] == i % NC)
        else report_mismatch("task_valid_o lane", grant_log[i], i % NC);
    end
    repeat (20) begin
      next_cycle();
      assert (task_cnt == SLOTS) else fail_run("Task issued while all slots were held");
      assert (her_acc == SLOTS + HD)
        else report_mismatch("HER accept count", her_acc, SLOTS + HD);
      assert (!her_ready) else report_mismatch("her_ready_o", her_ready, 0);
    end

    // Returning feedback resumes dispatch
    fb_hold = 1'b0;
    while (fb_delivered < 20) next_cycle();

    // With the NIC stalled only the feedback queue depth is taken from the clusters
    nic_mode   = 2'd0;
    fb_hold    = 1'b1;
    her_budget = 28;
    while (task_cnt < 28) next_cycle();
    fb_base = fb_taken;
    fb_hold = 1'b0;
    while (fb_taken < fb_base + FD) next_cycle();
    repeat (20) begin
      next_cycle();
      assert (fb_taken == fb_base + FD)
        else report_mismatch("feedback taken", fb_taken - fb_base, FD);
      assert (cluster_fb_ready == '0)
        else report_mismatch("cluster_fb_ready_o", cluster_fb_ready, 0);
    end
    nic_mode = 2'd1;
    while (fb_delivered < 28) next_cycle();

    // Throttled clusters and NIC
    task_pattern = 1'b1;
    nic_mode     = 2'd2;
    her_budget   = NUM_HERS;
    while (fb_delivered < NUM_HERS) next_cycle();

    // Queues drained and lanes idle once the NIC stops
    nic_mode = 2'd0;
    repeat (10) next_cycle();
    assert (!nic_fb_valid && task_valid == '0 && her_ready)
      else fail_run("Traffic left in the DUT after the last feedback");
    $display("Everything OK");
    $finish;
  end

endmodule

// File: sim.f
pspin_sched_pkg.sv
desc_fifo.sv
cluster_credit_ctr.sv
task_dispatch_fsm.sv
feedback_collect.sv
pspin_sched_top.sv
tb_pspin_sched.sv

// File: Bender.yml
package:
  name: pspin_sched

sources:
  - pspin_sched_pkg.sv
  - desc_fifo.sv
  - cluster_credit_ctr.sv
  - task_dispatch_fsm.sv
  - feedback_collect.sv
  - pspin_sched_top.sv
  - target: test
    files:
      - tb_pspin_sched.sv
